/* clockDisplay.sv */
`timescale 1ns/1ps

module clockDisplay import vgaPkg::*, rtcPkg::*; #(
	parameter int HActive = 640, // 640x480 at 25 MHz by default
	parameter int HFront = 16,
	parameter int HSync = 96,
	parameter int HBack = 48,
	parameter int VActive = 480,
	parameter int VFront = 10,
	parameter int VSync = 2,
	parameter int VBack = 33,
	parameter int OriginX = 220, // Panel roughly centred
	parameter int OriginY = 140,
	parameter int PanelW = 200,
	parameter int PanelH = 200,
	parameter int CellW = 20,
	parameter int CellH = 30,
	parameter int PairGap = 10,
	parameter int RowPitch = 60
) (
	input logic CLK,
	input logic arstN,
	input apbReqT apbReq,
	output apbRspT apbRsp,
	output videoOutT video
);

	clockValT clockVal;
	coordT hPos;
	coordT vPos;
	logic active;
	logic hSyncRaw;
	logic vSyncRaw;
	regionT region; // Decoder to renderer
	nibbleT nibble;
	cellPosT cellPos;
	logic activeD;
	logic hSyncD;
	logic vSyncD;

	////////////////////
	// Bus side
	////////////////////

	rtcRegs regs_i (
		.CLK(CLK), .arstN(arstN), .apbReq(apbReq), .apbRsp(apbRsp), .clockVal(clockVal)
	);

	////////////////////
	// Video pipeline, two stages after the counters
	////////////////////

	vgaTiming #(
		.HActive(HActive), .HFront(HFront), .HSync(HSync), .HBack(HBack),
		.VActive(VActive), .VFront(VFront), .VSync(VSync), .VBack(VBack)
	) timing_i (
		.CLK(CLK), .arstN(arstN), .hPos(hPos), .vPos(vPos), .active(active),
		.hSyncRaw(hSyncRaw), .vSyncRaw(vSyncRaw)
	);

	regionDecode #(
		.OriginX(OriginX), .OriginY(OriginY), .PanelW(PanelW), .PanelH(PanelH),
		.CellW(CellW), .CellH(CellH), .PairGap(PairGap), .RowPitch(RowPitch)
	) decode_i (
		.CLK(CLK), .arstN(arstN), .hPos(hPos), .vPos(vPos), .active(active),
		.hSyncRaw(hSyncRaw), .vSyncRaw(vSyncRaw), .clockVal(clockVal),
		.region(region), .nibble(nibble), .cellPos(cellPos),
		.activeD(activeD), .hSyncD(hSyncD), .vSyncD(vSyncD)
	);

	glyphRender #(.CellW(CellW), .CellH(CellH)) render_i (
		.CLK(CLK), .arstN(arstN), .region(region), .nibble(nibble), .cellPos(cellPos),
		.activeD(activeD), .hSyncD(hSyncD), .vSyncD(vSyncD), .video(video)
	);

endmodule

/* clockDisplay_chk.sv */
`timescale 1ns/1ps

module clockDisplay_chk import rtcPkg::*; #(
	parameter int HSyncLen = 1 // Expected hSync pulse width in cycles
) (
	input logic CLK,
	input logic arstN,
	input apbReqT apbReq,
	input apbRspT apbRsp,
	input clockValT clockVal,
	input logic hSync
);

	int lowCnt; // Cycles hSync has been low so far

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			lowCnt <= 0;
		end else if (!hSync) begin
			lowCnt <= lowCnt + 1;
		end else begin
			lowCnt <= 0; // Pulse over
		end
	end

	// Zero wait states, every access phase completes at once
	readyInAccess: assert property (@(posedge CLK) disable iff (!arstN)
		apbReq.penable |-> apbRsp.pready)
		else $error("pready low while penable high");

	syncWidth: assert property (@(posedge CLK) disable iff (!arstN)
		$rose(hSync) |-> (lowCnt == HSyncLen))
		else $error("hSync pulse lasted %0d cycles", lowCnt);

	// Registers move only on a write access
	noSpuriousWrite: assert property (@(posedge CLK) disable iff (!arstN)
		!(apbReq.psel && apbReq.penable && apbReq.pwrite) |=> $stable(clockVal))
		else $error("register contents changed without an APB write");

endmodule

////////////////////
// Attach to the bus slave and to the raster counters
////////////////////

bind rtcRegs clockDisplay_chk chkRegs_i (
	.CLK(CLK), .arstN(arstN), .apbReq(apbReq), .apbRsp(apbRsp),
	.clockVal(clockVal), .hSync(1'b1)
);

bind vgaTiming clockDisplay_chk #(.HSyncLen(HSync)) chkTiming_i (
	.CLK(CLK), .arstN(arstN), .apbReq('0), .apbRsp('0),
	.clockVal('0), .hSync(hSyncRaw)
);

/* clockDisplay_tb.sv */
`timescale 1ns/1ps

module clockDisplay_tb import vgaPkg::*, rtcPkg::*; ();

	localparam int HActive = 80; // Small raster keeps a frame short
	localparam int HFront = 4;
	localparam int HSync = 8;
	localparam int HBack = 6;
	localparam int VActive = 48;
	localparam int VFront = 2;
	localparam int VSync = 3;
	localparam int VBack = 3;
	localparam int OriginX = 4;
	localparam int OriginY = 4;
	localparam int PanelW = 60;
	localparam int PanelH = 40;
	localparam int CellW = 4;
	localparam int CellH = 7;
	localparam int PairGap = 2;
	localparam int RowPitch = 10;
	localparam int HTotal = HActive + HFront + HSync + HBack;
	localparam int VTotal = VActive + VFront + VSync + VBack;
	localparam int ClkPeriod = 100;
	localparam int NumTests = 6;
	localparam longint TimeoutNs = longint'(NumTests) * 10 * HTotal * VTotal * ClkPeriod;
	localparam int ApbWaitMax = 16; // Bound on pready wait

	// Digits lighting each segment, bit k set for digit k
	localparam logic [9:0] SegA = 10'b1111101101;
	localparam logic [9:0] SegB = 10'b1110011111;
	localparam logic [9:0] SegC = 10'b1111111011;
	localparam logic [9:0] SegD = 10'b1101101101;
	localparam logic [9:0] SegE = 10'b0101000101;
	localparam logic [9:0] SegF = 10'b1101110001;
	localparam logic [9:0] SegG = 10'b1101111100;

	logic CLK;
	logic arstN;
	apbReqT apbReq;
	apbRspT apbRsp;
	videoOutT video;
	logic [15:0] lfsr = 16'd67; // Seed
	logic [2:0][23:0] shownRows = '0; // Model copy: date, time, timer
	logic shownAlarm = 1'b0;

	initial apbReq = '0; // Bus idle from time 0

	tbClk #(.Period(ClkPeriod), .ResetCycles(2)) clk_i (.CLK(CLK), .arstN(arstN));

	clockDisplay #(
		.HActive(HActive), .HFront(HFront), .HSync(HSync), .HBack(HBack),
		.VActive(VActive), .VFront(VFront), .VSync(VSync), .VBack(VBack),
		.OriginX(OriginX), .OriginY(OriginY), .PanelW(PanelW), .PanelH(PanelH),
		.CellW(CellW), .CellH(CellH), .PairGap(PairGap), .RowPitch(RowPitch)
	) dut_i (.CLK(CLK), .arstN(arstN), .apbReq(apbReq), .apbRsp(apbRsp), .video(video));

	////////////////////
	// Reporting
	////////////////////

	task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic abortRun(string why);
		$display("Run aborted: %s", why);
		$display("=== FAIL ===");
		$fatal(1, "%s", why);
	endtask

	// Whole run gets ten frames per test
	initial begin
		#(TimeoutNs);
		abortRun("watchdog expired before the tests finished");
	end

	////////////////////
	// Random BCD
	////////////////////

	function automatic logic nextBit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // x^16+x^14+x^13+x^11+1
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic nibbleT bcdDigit();
		nibbleT n;
		for (int i = 0; i < 4; i++) n = {n[2:0], nextBit()};
		return (n > 4'd9) ? n - 4'd10 : n; // Fold 10..15 onto 0..5
	endfunction

	function automatic logic [23:0] bcdField();
		logic [23:0] f;
		for (int i = 0; i < 6; i++) f = {f[19:0], bcdDigit()};
		return f;
	endfunction

	////////////////////
	// APB
	////////////////////

	task automatic busTransfer(input logic write, input apbAddrT addr, input apbDataT wdata,
			output apbDataT rdata, output logic err);
		int waits;
		waits = 0;
		@(posedge CLK);
		apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge CLK);
		apbReq.penable <= 1'b1; // Access phase
		@(negedge CLK);
		while (apbRsp.pready !== 1'b1) begin
			waits++;
			if (waits > ApbWaitMax) abortRun("pready never came during an APB access");
			@(negedge CLK);
		end
		rdata = apbRsp.prdata;
		err = apbRsp.pslverr;
		@(posedge CLK); // Write lands on this edge
		apbReq <= '0;
	endtask

	// Also updates the model per the register map
	task automatic writeReg(apbAddrT addr, apbDataT data);
		apbDataT rd;
		logic err;
		busTransfer(1'b1, addr, data, rd, err);
		compare("pslverr", 32'(err), 32'd0);
		case (addr)
			addrDate: shownRows[0] = data[23:0];
			addrTime: shownRows[1] = data[23:0];
			addrTimer: shownRows[2] = data[23:0];
			default: shownAlarm = data[0];
		endcase
	endtask

	task automatic readReg(apbAddrT addr, apbDataT exp);
		apbDataT rd;
		logic err;
		busTransfer(1'b0, addr, '0, rd, err);
		compare("pslverr", 32'(err), 32'd0);
		compare("prdata", rd, exp);
	endtask

	////////////////////
	// Pixel model
	////////////////////

	function automatic logic segmentLit(nibbleT d, int cx, int cy);
		int mid;
		mid = CellH / 2;
		if (d > 4'd9) return 1'b0; // Not BCD, blank
		return (cy == 0 && SegA[d]) || (cy == mid && SegG[d]) || (cy == CellH - 1 && SegD[d]) ||
			(cx == CellW - 1 && cy < mid && SegB[d]) || (cx == CellW - 1 && cy > mid && SegC[d]) ||
			(cx == 0 && cy < mid && SegF[d]) || (cx == 0 && cy > mid && SegE[d]);
	endfunction

	function automatic colorT pixelColor(int x, int y);
		int cx;
		int cy;
		if (x >= HActive || y >= VActive) return colBlack;
		if (x < OriginX || x >= OriginX + PanelW || y < OriginY || y >= OriginY + PanelH)
			return colBlack; // Border
		if (shownAlarm && x >= OriginX + PanelW - 2 - CellW && x < OriginX + PanelW - 2 &&
				y >= OriginY + PanelH - 2 - CellW && y < OriginY + PanelH - 2)
			return colAlarm;
		for (int row = 0; row < 3; row++) begin
			cy = y - (OriginY + 2 + row * RowPitch);
			for (int col = 0; col < 6; col++) begin
				cx = x - (OriginX + 2 + (col / 2) * (2 * CellW + PairGap) + (col % 2) * CellW);
				if (cx >= 0 && cx < CellW && cy >= 0 && cy < CellH)
					return segmentLit(shownRows[row][23 - 4 * col -: 4], cx, cy) ?
						colSegment : colPanel;
			end
		end
		return colPanel;
	endfunction

	// One whole frame from the vSync fall, syncs included
	task automatic compareFrame();
		int h;
		int v;
		logic expH;
		logic expV;
		@(negedge CLK);
		while (video.vSync !== 1'b1) @(negedge CLK);
		while (video.vSync === 1'b1) @(negedge CLK);
		h = 0;
		v = VActive + VFront; // First sync line
		repeat (HTotal * VTotal) begin
			expH = !(h >= HActive + HFront && h < HActive + HFront + HSync);
			expV = !(v >= VActive + VFront && v < VActive + VFront + VSync);
			compare("video.color", 32'(video.color), 32'(pixelColor(h, v)));
			compare("video.hSync", 32'(video.hSync), 32'(expH));
			compare("video.vSync", 32'(video.vSync), 32'(expV));
			h++;
			if (h == HTotal) begin
				h = 0;
				v = (v + 1) % VTotal;
			end
			@(negedge CLK);
		end
	endtask

	// Cycles a sync stays at one level, sampled on falling edges
	task automatic runLength(input logic vert, input logic level, output int n);
		n = 0;
		while ((vert ? video.vSync : video.hSync) === level) begin
			n++;
			@(negedge CLK);
		end
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic resetValues();
		@(posedge CLK);
		@(negedge CLK); // Still in reset here
		compare("video.hSync", 32'(video.hSync), 32'd1);
		compare("video.vSync", 32'(video.vSync), 32'd1);
		compare("video.color", 32'(video.color), 32'(colBlack));
		wait (arstN === 1'b1);
		readReg(addrDate, '0);
		readReg(addrTime, '0);
		readReg(addrTimer, '0);
	endtask

	task automatic registerReadback();
		apbDataT rd;
		logic err;
		writeReg(addrDate, 32'hFF12_3456); // Upper byte is unused
		writeReg(addrTime, 32'h0023_5959);
		writeReg(addrTimer, 32'h0001_3045);
		writeReg(addrCtrl, 32'hFFFF_FFFF);
		readReg(addrDate, 32'h0012_3456);
		readReg(addrTime, 32'h0023_5959);
		readReg(addrTimer, 32'h0001_3045);
		readReg(addrCtrl, 32'h1);
		busTransfer(1'b1, 4'h5, 32'h0099_9999, rd, err); // Misaligned write
		compare("pslverr", 32'(err), 32'd1);
		busTransfer(1'b0, 4'h2, '0, rd, err);
		compare("pslverr", 32'(err), 32'd1);
		readReg(addrDate, 32'h0012_3456);
		readReg(addrTime, 32'h0023_5959);
		readReg(addrTimer, 32'h0001_3045);
		readReg(addrCtrl, 32'h1);
		writeReg(addrCtrl, 32'h0);
	endtask

	task automatic rasterPeriods();
		int lowLen;
		int highLen;
		@(negedge CLK);
		for (int vert = 0; vert < 2; vert++) begin
			runLength(vert[0], 1'b0, lowLen); // Skip a pulse in progress
			runLength(vert[0], 1'b1, highLen);
			runLength(vert[0], 1'b0, lowLen);
			runLength(vert[0], 1'b1, highLen);
			if (vert == 0) begin
				compare("hSync low cycles", 32'(lowLen), 32'(HSync));
				compare("line cycles", 32'(lowLen + highLen), 32'(HTotal));
			end else begin
				compare("vSync low cycles", 32'(lowLen), 32'(VSync * HTotal));
				compare("frame cycles", 32'(lowLen + highLen), 32'(VTotal * HTotal));
			end
		end
	endtask

	task automatic randomDigitFrame();
		writeReg(addrDate, {8'h00, bcdField()});
		writeReg(addrTime, {8'h00, bcdField()});
		writeReg(addrTimer, {8'h00, bcdField()});
		compareFrame();
	endtask

	task automatic alarmToggle();
		writeReg(addrCtrl, 32'h1);
		compareFrame(); // Icon lit
		writeReg(addrCtrl, 32'h0);
		compareFrame(); // Back to panel colour
	endtask

	task automatic blankNibble();
		writeReg(addrDate, 32'h001A_F3C9); // A, F and C blank
		writeReg(addrTimer, 32'h00B0_7DE8);
		compareFrame();
	endtask

	initial begin
		resetValues();
		registerReadback();
		rasterPeriods();
		randomDigitFrame();
		alarmToggle();
		blankNibble();
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* glyphRender.sv */
`timescale 1ns/1ps

module glyphRender import vgaPkg::*; #(
	parameter int CellW = 20, // Must match the decoder cell size
	parameter int CellH = 30
) (
	input logic CLK,
	input logic arstN,
	input regionT region,
	input nibbleT nibble,
	input cellPosT cellPos,
	input logic activeD,
	input logic hSyncD,
	input logic vSyncD,
	output videoOutT video
);

	localparam cellCoordT MidRow = cellCoordT'(CellH / 2); // Segment g
	localparam cellCoordT LastRow = cellCoordT'(CellH - 1); // Segment d
	localparam cellCoordT LastCol = cellCoordT'(CellW - 1); // Segments b and c

	logic [6:0] segs; // {a, b, c, d, e, f, g}
	logic onTop;
	logic onMid;
	logic onBot;
	logic onLeft;
	logic onRight;
	logic upper; // Above the middle row
	logic lower; // Below it
	logic lit;
	colorT colorN;

	////////////////////
	// Seven segment rule
	////////////////////

	always_comb begin
		case (nibble)
			4'd0: segs = 7'b1111110;
			4'd1: segs = 7'b0110000;
			4'd2: segs = 7'b1101101;
			4'd3: segs = 7'b1111001;
			4'd4: segs = 7'b0110011;
			4'd5: segs = 7'b1011011;
			4'd6: segs = 7'b1011111;
			4'd7: segs = 7'b1110000;
			4'd8: segs = 7'b1111111;
			4'd9: segs = 7'b1111011;
			default: segs = 7'b0000000; // Not BCD, blank cell
		endcase
	end

	assign onTop = (cellPos.cellY == '0);
	assign onMid = (cellPos.cellY == MidRow);
	assign onBot = (cellPos.cellY == LastRow);
	assign onLeft = (cellPos.cellX == '0);
	assign onRight = (cellPos.cellX == LastCol);
	assign upper = (cellPos.cellY < MidRow);
	assign lower = (cellPos.cellY > MidRow);

	// Horizontal bars span the full cell width
	assign lit = (onTop & segs[6]) | (onMid & segs[0]) | (onBot & segs[3]) |
		(onRight & upper & segs[5]) | (onRight & lower & segs[4]) |
		(onLeft & upper & segs[1]) | (onLeft & lower & segs[2]);

	////////////////////
	// Colour choice
	////////////////////

	always_comb begin
		if (!activeD) begin
			colorN = colBlack; // Blanking
		end else begin
			case (region)
				regPanel: colorN = colPanel;
				regDigit: colorN = lit ? colSegment : colPanel;
				regAlarm: colorN = colAlarm;
				default: colorN = colBlack; // Border around the panel
			endcase
		end
	end

	// Output stage, syncs travel with their own pixel
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			video.hSync <= 1'b1;
			video.vSync <= 1'b1;
			video.color <= colBlack;
		end else begin
			video.hSync <= hSyncD;
			video.vSync <= vSyncD;
			video.color <= colorN;
		end
	end

endmodule

/* list.f */
vgaPkg.sv
rtcPkg.sv
vgaTiming.sv
rtcRegs.sv
regionDecode.sv
glyphRender.sv
clockDisplay.sv
tbClk.sv
clockDisplay_chk.sv
clockDisplay_tb.sv

/* regionDecode.sv */
`timescale 1ns/1ps

module regionDecode import vgaPkg::*, rtcPkg::*; #(
	parameter int OriginX = 220, // Panel top left
	parameter int OriginY = 140,
	parameter int PanelW = 200,
	parameter int PanelH = 200,
	parameter int CellW = 20, // Digit cell size
	parameter int CellH = 30,
	parameter int PairGap = 10, // Space between digit pairs
	parameter int RowPitch = 60 // Row start to row start
) (
	input logic CLK,
	input logic arstN,
	input coordT hPos,
	input coordT vPos,
	input logic active,
	input logic hSyncRaw,
	input logic vSyncRaw,
	input clockValT clockVal,
	output regionT region,
	output nibbleT nibble,
	output cellPosT cellPos,
	output logic activeD,
	output logic hSyncD,
	output logic vSyncD
);

	localparam int RowX0 = OriginX + 2; // First cell column
	localparam int RowY0 = OriginY + 2; // Date row top
	localparam int PairStep = 2 * CellW + PairGap;
	localparam int AlarmX0 = OriginX + PanelW - 2 - CellW; // Bottom right, inset 2
	localparam int AlarmY0 = OriginY + PanelH - 2 - CellW;

	int xi; // Beam position widened for signed-free compares
	int yi;
	int x0; // Current cell origin in the loop
	int y0;
	logic inPanel;
	logic inAlarm;
	logic [2:0][23:0] rowDigits; // Six nibbles per row, tens first
	regionT regionN;
	nibbleT nibbleN;
	cellPosT cellN;

	assign rowDigits[0] = {clockVal.day, clockVal.month, clockVal.year};
	assign rowDigits[1] = {clockVal.hour, clockVal.minute, clockVal.second};
	assign rowDigits[2] = {clockVal.timerHour, clockVal.timerMinute, clockVal.timerSecond};

	////////////////////
	// Region lookup
	////////////////////

	always_comb begin
		xi = int'(hPos);
		yi = int'(vPos);
		x0 = 0;
		y0 = 0;
		inPanel = (xi >= OriginX) && (xi < OriginX + PanelW) &&
			(yi >= OriginY) && (yi < OriginY + PanelH);
		inAlarm = (xi >= AlarmX0) && (xi < AlarmX0 + CellW) &&
			(yi >= AlarmY0) && (yi < AlarmY0 + CellW);
		regionN = inPanel ? regPanel : regOff;
		nibbleN = '0;
		cellN = '0;
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 6; c++) begin
				x0 = RowX0 + (c / 2) * PairStep + (c % 2) * CellW; // Pairs sit back to back
				y0 = RowY0 + r * RowPitch;
				if ((xi >= x0) && (xi < x0 + CellW) && (yi >= y0) && (yi < y0 + CellH)) begin
					regionN = regDigit;
					nibbleN = rowDigits[r][23 - 4 * c -: 4];
					cellN.cellX = cellCoordT'(xi - x0);
					cellN.cellY = cellCoordT'(yi - y0);
				end
			end
		end
		if (inAlarm && clockVal.alarm) regionN = regAlarm; // Icon only while armed
	end

	////////////////////
	// Pipeline stage
	////////////////////

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			region <= regOff;
			activeD <= 1'b0;
			hSyncD <= 1'b1; // Syncs idle high
			vSyncD <= 1'b1;
		end else begin
			region <= regionN;
			activeD <= active;
			hSyncD <= hSyncRaw;
			vSyncD <= vSyncRaw;
		end
	end

	// Payload, only meaningful inside a digit cell
	always_ff @(posedge CLK) begin
		nibble <= nibbleN;
		cellPos <= cellN;
	end

endmodule

/* rtcPkg.sv */
package rtcPkg;

	typedef logic [7:0] bcdPairT; // Tens in 7:4, units in 3:0
	typedef logic [3:0] apbAddrT;
	typedef logic [31:0] apbDataT;

	// Everything the panel shows
	typedef struct packed {
		bcdPairT day;
		bcdPairT month;
		bcdPairT year;
		bcdPairT hour;
		bcdPairT minute;
		bcdPairT second;
		bcdPairT timerHour;
		bcdPairT timerMinute;
		bcdPairT timerSecond;
		logic alarm;
	} clockValT;

	////////////////////
	// APB
	////////////////////

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		apbAddrT paddr;
		apbDataT pwdata;
	} apbReqT;

	typedef struct packed {
		apbDataT prdata;
		logic pready;
		logic pslverr;
	} apbRspT;

	// Register map, byte addresses
	localparam apbAddrT addrDate = 4'h0; // Day, month, year in 23:0
	localparam apbAddrT addrTime = 4'h4; // Hour, minute, second
	localparam apbAddrT addrTimer = 4'h8; // Countdown hh:mm:ss
	localparam apbAddrT addrCtrl = 4'hC; // Alarm in bit 0

endpackage

/* rtcRegs.sv */
`timescale 1ns/1ps

module rtcRegs import rtcPkg::*; (
	input logic CLK,
	input logic arstN,
	input apbReqT apbReq,
	output apbRspT apbRsp,
	output clockValT clockVal
);

	logic access; // Access phase of a transfer
	logic addrOk; // Address hits one of the four registers
	logic wrEn;
	apbDataT rdData;
	clockValT regs;

	assign access = apbReq.psel & apbReq.penable;

	// Only word aligned hits are mapped
	always_comb begin
		case (apbReq.paddr)
			addrDate, addrTime, addrTimer, addrCtrl: addrOk = 1'b1;
			default: addrOk = 1'b0; // Misaligned
		endcase
	end

	assign wrEn = access & apbReq.pwrite & addrOk;

	////////////////////
	// Register write
	////////////////////

	// Fields kept exactly as written, no BCD check here
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			regs <= '0; // Blank date and time, alarm off
		end else if (wrEn) begin
			case (apbReq.paddr)
				addrDate: {regs.day, regs.month, regs.year} <= apbReq.pwdata[23:0];
				addrTime: {regs.hour, regs.minute, regs.second} <= apbReq.pwdata[23:0];
				addrTimer: begin
					{regs.timerHour, regs.timerMinute, regs.timerSecond} <=
						apbReq.pwdata[23:0];
				end
				addrCtrl: regs.alarm <= apbReq.pwdata[0];
				default: regs <= regs;
			endcase
		end
	end

	assign clockVal = regs; // Display reads the live copy

	////////////////////
	// Read mux
	////////////////////

	always_comb begin
		rdData = '0; // Unused bits read as 0
		case (apbReq.paddr)
			addrDate: rdData[23:0] = {regs.day, regs.month, regs.year};
			addrTime: rdData[23:0] = {regs.hour, regs.minute, regs.second};
			addrTimer: rdData[23:0] = {regs.timerHour, regs.timerMinute, regs.timerSecond};
			addrCtrl: rdData[0] = regs.alarm;
			default: rdData = '0;
		endcase
	end

	// Zero wait states
	assign apbRsp.prdata = access ? rdData : '0;
	assign apbRsp.pready = 1'b1;
	assign apbRsp.pslverr = access & ~addrOk; // Error only in the access phase

endmodule

/* run.sh */
#!/bin/sh
# Build and run the clock display testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module clockDisplay_tb \
	-Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* tbClk.sv */
`timescale 1ns/1ps

module tbClk #(
	parameter int Period = 100, // ns
	parameter int ResetCycles = 2
) (
	output logic CLK,
	output logic arstN
);

	initial begin
		CLK = 1'b0;
		forever #(Period / 2) CLK = ~CLK;
	end

	// Release on a falling edge, clear of the flops' active edge
	initial begin
		arstN = 1'b0;
		repeat (ResetCycles) @(posedge CLK);
		@(negedge CLK);
		arstN = 1'b1;
	end

endmodule

/* vgaPkg.sv */
package vgaPkg;

	////////////////////
	// Raster and pixel types
	////////////////////

	typedef logic [9:0] coordT; // Pixel coordinate or raster counter
	typedef logic [11:0] colorT; // RGB 4:4:4
	typedef logic [3:0] nibbleT; // One BCD digit
	typedef logic [4:0] cellCoordT; // Offset inside a digit cell

	// Video port, syncs are active low
	typedef struct packed {
		logic hSync;
		logic vSync;
		colorT color;
	} videoOutT;

	// What the pixel under the beam belongs to
	typedef enum logic [1:0] {
		regOff = 2'd0, // Outside the panel
		regPanel = 2'd1, // Panel background
		regDigit = 2'd2, // Inside one of the 18 digit cells
		regAlarm = 2'd3 // Alarm icon, only while the flag is set
	} regionT;

	// Position inside a cell, origin at the top left
	typedef struct packed {
		cellCoordT cellX;
		cellCoordT cellY;
	} cellPosT;

	////////////////////
	// Palette
	////////////////////

	localparam colorT colBlack = 12'h000; // Blanking and border
	localparam colorT colPanel = 12'h236; // Dark blue panel
	localparam colorT colSegment = 12'hFE2; // Lit segment, amber
	localparam colorT colAlarm = 12'hF20; // Alarm icon, red

endpackage

/* vgaTiming.sv */
`timescale 1ns/1ps

module vgaTiming import vgaPkg::*; #(
	parameter int HActive = 640, // Visible pixels per line
	parameter int HFront = 16,
	parameter int HSync = 96,
	parameter int HBack = 48,
	parameter int VActive = 480, // Visible lines per frame
	parameter int VFront = 10,
	parameter int VSync = 2,
	parameter int VBack = 33
) (
	input logic CLK,
	input logic arstN,
	output coordT hPos,
	output coordT vPos,
	output logic active,
	output logic hSyncRaw,
	output logic vSyncRaw
);

	localparam int HTotal = HActive + HFront + HSync + HBack;
	localparam int VTotal = VActive + VFront + VSync + VBack;

	// Sync windows, counted from the first active pixel
	localparam int HSyncStart = HActive + HFront;
	localparam int VSyncStart = VActive + VFront;

	coordT hCnt; // Pixel within the line
	coordT vCnt; // Line within the frame
	logic lineEnd;

	assign lineEnd = (hCnt == coordT'(HTotal - 1));

	////////////////////
	// Chained counters
	////////////////////

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			hCnt <= '0; // 0 is the first visible pixel
			vCnt <= '0;
		end else begin
			hCnt <= lineEnd ? '0 : hCnt + 1'b1;
			if (lineEnd) begin // Vertical steps once per line
				vCnt <= (vCnt == coordT'(VTotal - 1)) ? '0 : vCnt + 1'b1;
			end
		end
	end

	// Flags straight from the counters, the pipeline registers them later
	assign active = (hCnt < coordT'(HActive)) && (vCnt < coordT'(VActive));
	assign hSyncRaw = !((hCnt >= coordT'(HSyncStart)) &&
		(hCnt < coordT'(HSyncStart + HSync))); // Low inside the pulse
	assign vSyncRaw = !((vCnt >= coordT'(VSyncStart)) &&
		(vCnt < coordT'(VSyncStart + VSync)));

	assign hPos = hCnt;
	assign vPos = vCnt;

endmodule
